/* src/mboxCycle.sv */
`timescale 1ns/1ps
`default_nettype none

module mboxCycle #(
  parameter int memAddrW = 6
) (
  input  logic                      clk,
  input  logic                      arstN,
  input  mclPkg::memReqT            popData,
  input  logic                      empty,
  input  logic                      stall,
  output logic                      pop,
  output logic                      rdValid,
  output logic [mclPkg::wordW-1:0]  rdData,
  output logic                      rdToArx,
  output logic                      pageFail,
  output logic [mclPkg::vmaW-1:0]   failVma
);
  import mclPkg::*;

  localparam int memWords = 2 ** memAddrW;

  logic [wordW-1:0]    mem [memWords];
  logic [memAddrW-1:0] idx;
  logic                isRead;
  logic                doRead;
  logic                doWrite;
  logic                doFail;

  // Memory box takes the head whenever it is free
  assign pop = !empty && !stall;

  assign idx     = popData.vma[memAddrW-1:0];
  assign isRead  = popData.loadAr || popData.loadArx;
  assign doRead  = pop && isRead && !popData.adrErr;
  assign doWrite = pop && popData.vmaWrite && !popData.adrErr;
  assign doFail  = pop && popData.adrErr;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rdValid  <= 1'b0;
      pageFail <= 1'b0;
    end else begin
      rdValid  <= doRead;
      pageFail <= doFail;
    end
  end

  // Read sees the old word, so rw and rpw return it
  always_ff @(posedge clk) begin
    if (pop) begin
      rdData  <= mem[idx];
      rdToArx <= popData.loadArx && !popData.loadAr;
      failVma <= popData.vma;
    end
    if (doWrite) begin
      mem[idx] <= popData.wrData;
    end
  end

  resultExclusive: assert property (
    @(posedge clk) disable iff (!arstN)
    !(rdValid && pageFail)
  ) else $error("rdValid and pageFail high together");

endmodule

`default_nettype wire

/* src/mclPkg.sv */
`default_nettype none

package mclPkg;

  // Microcode memory-field functions
  typedef enum logic [3:0] {
    nop         = 4'd0,
    loadAr      = 4'd1,
    loadArx     = 4'd2,
    rwCycle     = 4'd3,
    rpwCycle    = 4'd4,
    write       = 4'd5,
    uncondFetch = 4'd6,
    adFunc      = 4'd7
  } memFuncT;

  localparam int wordW    = 36;
  localparam int vaW      = 30;
  localparam int offsetW  = 18;
  // Legal sections are 0 to 31
  localparam int sectionW = 5;
  localparam int vmaW     = sectionW + offsetW;
  localparam int magicW   = 9;
  localparam int heldW    = 12;

  // One decoded memory request
  typedef struct packed {
    logic             loadAr;
    logic             loadArx;
    logic             vmaPause;
    logic             vmaWrite;
    logic             vmaUser;
    logic             vmaPublic;
    logic             vmaPrevious;
    logic             vmaFetch;
    logic [vmaW-1:0]  vma;
    logic             adrErr;
    logic [wordW-1:0] wrData;
  } memReqT;

endpackage

`default_nettype wire

/* src/memCtlDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtlDecode (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          memStrobe,
  input  mclPkg::memFuncT               memFunc,
  input  logic [mclPkg::magicW-1:0]     magic,
  input  logic [mclPkg::vaW-1:0]        adBus,
  input  logic [mclPkg::wordW-1:0]      wrData,
  input  logic                          pcUser,
  input  logic                          pcPublic,
  input  logic [mclPkg::sectionW-1:0]   pcSection,
  input  logic                          loadHeld,
  input  logic                          condSelVma,
  input  logic                          full,
  output logic                          push,
  output mclPkg::memReqT                pushData,
  output logic [mclPkg::heldW-1:0]      heldOrPc
);
  import mclPkg::*;

  memReqT              nextReq;
  logic                reqFire;
  logic                isLong;
  logic                highBits;
  logic [sectionW-1:0] section;
  logic [heldW-1:0]    heldReg;

  assign reqFire = memStrobe && (memFunc != nop);

  // Long addressing pulls the section off the operand bus
  assign isLong   = magic[7];
  assign highBits = |adBus[vaW-1:offsetW+sectionW];
  assign section  = isLong ? adBus[offsetW +: sectionW] : pcSection;

  always_comb begin
    nextReq = '0;

    case (memFunc)
      loadAr: begin
        nextReq.loadAr = 1'b1;
      end
      loadArx: begin
        nextReq.loadArx = 1'b1;
      end
      rwCycle: begin
        nextReq.loadAr   = 1'b1;
        nextReq.vmaWrite = 1'b1;
      end
      rpwCycle: begin
        nextReq.loadAr   = 1'b1;
        nextReq.vmaPause = 1'b1;
        nextReq.vmaWrite = 1'b1;
      end
      write: begin
        nextReq.vmaWrite = 1'b1;
      end
      uncondFetch: begin
        nextReq.loadArx  = 1'b1;
        nextReq.vmaFetch = 1'b1;
      end
      adFunc: begin
        // Cycle flags straight off the operand bus
        nextReq.loadAr   = adBus[1];
        nextReq.loadArx  = adBus[2];
        nextReq.vmaPause = adBus[3];
        nextReq.vmaWrite = adBus[4];
      end
      default: begin
        nextReq.loadAr = 1'b0;
      end
    endcase

    // Context
    if (memFunc == adFunc) begin
      nextReq.vmaUser   = adBus[5];
      nextReq.vmaPublic = adBus[6];
    end else begin
      nextReq.vmaUser   = pcUser;
      nextReq.vmaPublic = pcPublic;
    end
    nextReq.vmaPrevious = magic[5];

    nextReq.vma    = {section, adBus[offsetW-1:0]};
    nextReq.adrErr = isLong && highBits;
    nextReq.wrData = wrData;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      push <= 1'b0;
    end else begin
      push <= reqFire;
    end
  end

  always_ff @(posedge clk) begin
    if (reqFire) begin
      pushData <= nextReq;
    end
  end

  // Held copy of the last cycle for readback
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      heldReg <= '0;
    end else if (loadHeld) begin
      heldReg <= {{(heldW-8){1'b0}},
                  pushData.loadAr, pushData.loadArx,
                  pushData.vmaPause, pushData.vmaWrite,
                  pushData.vmaUser, pushData.vmaPublic,
                  pushData.vmaPrevious, pushData.vmaFetch};
    end
  end

  assign heldOrPc = condSelVma ? heldReg :
                    {{(heldW-2-sectionW){1'b0}}, pcUser, pcPublic, pcSection};

  // Source must honor ready
  strobeNotFull: assert property (
    @(posedge clk) disable iff (!arstN)
    memStrobe |-> !full
  ) else $error("memStrobe raised while queue full");

  pushFollowsStrobe: assert property (
    @(posedge clk) disable iff (!arstN)
    push |-> $past(memStrobe && (memFunc != nop))
  ) else $error("push without a preceding memory strobe");

endmodule

`default_nettype wire

/* src/memCtlTop.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtlTop #(
  parameter int queueDepth = 4,
  parameter int memAddrW   = 6
) (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          memStrobe,
  input  mclPkg::memFuncT               memFunc,
  input  logic [mclPkg::magicW-1:0]     magic,
  input  logic [mclPkg::vaW-1:0]        adBus,
  input  logic [mclPkg::wordW-1:0]      wrData,
  input  logic                          pcUser,
  input  logic                          pcPublic,
  input  logic [mclPkg::sectionW-1:0]   pcSection,
  input  logic                          loadHeld,
  input  logic                          condSelVma,
  input  logic                          stall,
  output logic                          ready,
  output logic [mclPkg::heldW-1:0]      heldOrPc,
  output logic                          rdValid,
  output logic [mclPkg::wordW-1:0]      rdData,
  output logic                          rdToArx,
  output logic                          pageFail,
  output logic [mclPkg::vmaW-1:0]       failVma
);
  import mclPkg::*;

  logic   push;
  logic   pop;
  logic   full;
  logic   empty;
  memReqT pushData;
  memReqT popData;

  assign ready = !full;

  memCtlDecode decode (
    .clk        (clk),
    .arstN      (arstN),
    .memStrobe  (memStrobe),
    .memFunc    (memFunc),
    .magic      (magic),
    .adBus      (adBus),
    .wrData     (wrData),
    .pcUser     (pcUser),
    .pcPublic   (pcPublic),
    .pcSection  (pcSection),
    .loadHeld   (loadHeld),
    .condSelVma (condSelVma),
    .full       (full),
    .push       (push),
    .pushData   (pushData),
    .heldOrPc   (heldOrPc)
  );

  reqQueue #(
    .payloadT (memReqT),
    .depth    (queueDepth)
  ) queue (
    .clk      (clk),
    .arstN    (arstN),
    .push     (push),
    .pushData (pushData),
    .pop      (pop),
    .popData  (popData),
    .full     (full),
    .empty    (empty)
  );

  mboxCycle #(
    .memAddrW (memAddrW)
  ) mbox (
    .clk      (clk),
    .arstN    (arstN),
    .popData  (popData),
    .empty    (empty),
    .stall    (stall),
    .pop      (pop),
    .rdValid  (rdValid),
    .rdData   (rdData),
    .rdToArx  (rdToArx),
    .pageFail (pageFail),
    .failVma  (failVma)
  );

endmodule

`default_nettype wire

/* src/reqQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module reqQueue #(
  parameter type payloadT = logic,
  parameter int  depth    = 4
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    push,
  input  payloadT pushData,
  input  logic    pop,
  output payloadT popData,
  output logic    full,
  output logic    empty
);

  localparam int ptrW = $clog2(depth);
  localparam int cntW = $clog2(depth + 1);

  payloadT           buffer [depth];
  logic [ptrW-1:0]   wrPtr;
  logic [ptrW-1:0]   rdPtr;
  logic [cntW-1:0]   count;

  always_ff @(posedge clk) begin
    if (push) begin
      buffer[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Empty queue passes an arriving entry straight to the head
  assign empty   = (count == '0) && !push;
  assign popData = (count == '0) ? pushData : buffer[rdPtr];

  // An arriving push holds off the next strobe
  assign full = (count == cntW'(depth)) || (push && (count == cntW'(depth - 1)));

  noOverflow: assert property (
    @(posedge clk) disable iff (!arstN)
    push |-> (count < cntW'(depth))
  ) else $error("push into a full queue");

  noUnderflow: assert property (
    @(posedge clk) disable iff (!arstN)
    pop |-> !empty
  ) else $error("pop from an empty queue");

endmodule

`default_nettype wire

/* tb.f */
src/mclPkg.sv
src/memCtlDecode.sv
src/reqQueue.sv
src/mboxCycle.sv
src/memCtlTop.sv
verif/memCtlChecks.sv
verif/memCtlTb.sv

/* verif/memCtlChecks.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtlChecks (
  input logic                      clk,
  input logic                      arstN,
  input logic                      memStrobe,
  input logic                      ready,
  input logic                      rdValid,
  input logic [mclPkg::wordW-1:0]  rdData,
  input logic                      rdToArx,
  input logic                      pageFail,
  input logic [mclPkg::vmaW-1:0]   failVma,
  input logic [mclPkg::heldW-1:0]  heldOrPc,
  input logic                      idle,
  input logic                      resultDue,
  input logic                      expPending,
  input logic                      expIsFail,
  input logic [mclPkg::wordW-1:0]  expData,
  input logic                      expToArx,
  input logic [mclPkg::vmaW-1:0]   expVma,
  input logic                      heldCheck,
  input logic [mclPkg::heldW-1:0]  expHeld
);
  import mclPkg::*;

  int mismatchCount = 0;
  int otherCount    = 0;

  task automatic reportMismatch(input string name, input logic [wordW-1:0] got,
                                input logic [wordW-1:0] want);
    mismatchCount++;
    $display("Mismatch %s: got 'h%0h, expected 'h%0h at %0t", name, got, want, $time);
  endtask

  task automatic noteFailure(input string what);
    otherCount++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // Quiet outputs until the first request
  idleQuiet: assert property (@(posedge clk) disable iff (!arstN)
    idle |-> ready && !rdValid && !pageFail)
    else noteFailure("result outputs active before any strobe");

  strobeReady: assert property (@(posedge clk) disable iff (!arstN)
    memStrobe |-> ready)
    else noteFailure("strobe driven while ready was low");

  resultOnTime: assert property (@(posedge clk) disable iff (!arstN)
    memStrobe && resultDue |-> ##2 (rdValid || pageFail))
    else noteFailure("no result two cycles after an unstalled strobe");

  // Kind of result must match the oldest outstanding request
  resultKind: assert property (@(posedge clk) disable iff (!arstN)
    rdValid || pageFail |-> expPending && (pageFail == expIsFail))
    else noteFailure("result pulse of the wrong kind or with nothing outstanding");

  rdDataMatch: assert property (@(posedge clk) disable iff (!arstN)
    rdValid && expPending && !expIsFail |-> rdData == expData)
    else reportMismatch("rdData", $sampled(rdData), $sampled(expData));

  rdToArxMatch: assert property (@(posedge clk) disable iff (!arstN)
    rdValid && expPending && !expIsFail |-> rdToArx == expToArx)
    else reportMismatch("rdToArx", $sampled(rdToArx), $sampled(expToArx));

  failVmaMatch: assert property (@(posedge clk) disable iff (!arstN)
    pageFail && expPending && expIsFail |-> failVma == expVma)
    else reportMismatch("failVma", $sampled(failVma), $sampled(expVma));

  heldMatch: assert property (@(posedge clk) disable iff (!arstN)
    heldCheck |-> heldOrPc == expHeld)
    else reportMismatch("heldOrPc", $sampled(heldOrPc), $sampled(expHeld));

endmodule

`default_nettype wire

/* verif/memCtlTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtlTb;
  import mclPkg::*;

  localparam int queueDepth = 4;
  localparam int memAddrW   = 6;
  localparam int randOps    = 32;
  localparam int rmwOps     = 6;
  localparam int errOps     = 4;
  localparam int heldOps    = 3;
  localparam int totalOps   = 2 ** memAddrW + randOps + 2 * (rmwOps + errOps + queueDepth)
                              + heldOps;

  typedef struct packed {
    logic             isFail;
    logic             toArx;
    logic [wordW-1:0] data;
    logic [vmaW-1:0]  vma;
  } expT;

  logic                clk;
  logic                arstN;
  logic                memStrobe;
  memFuncT             memFunc;
  logic [magicW-1:0]   magic;
  logic [vaW-1:0]      adBus;
  logic [wordW-1:0]    wrData;
  logic                pcUser;
  logic                pcPublic;
  logic [sectionW-1:0] pcSection;
  logic                loadHeld;
  logic                condSelVma;
  logic                stall;
  logic                ready;
  logic [heldW-1:0]    heldOrPc;
  logic                rdValid;
  logic [wordW-1:0]    rdData;
  logic                rdToArx;
  logic                pageFail;
  logic [vmaW-1:0]     failVma;

  // Reference model and the expected head seen by the checker
  logic [wordW-1:0]    refMem [2 ** memAddrW];
  expT                 expQ [$];
  logic [heldW-1:0]    lastHeld;
  logic                idle;
  logic                resultDue;
  logic                heldCheck;
  logic                expPending;
  logic                expIsFail;
  logic                expToArx;
  logic [wordW-1:0]    expData;
  logic [vmaW-1:0]     expVma;
  logic [heldW-1:0]    expHeld;
  int                  seed = 61309;

  memCtlTop #(.queueDepth(queueDepth), .memAddrW(memAddrW)) uut (.*);
  memCtlChecks checks (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (totalOps * 20 + 100) @(posedge clk);
    $display("Watchdog expired with tests still running");
    $display("Result: FAILED");
    $finish;
  end

  // Retire the oldest entry when its result shows up
  always @(posedge clk) begin
    if (arstN && (rdValid || pageFail) && expQ.size() != 0) begin
      void'(expQ.pop_front());
    end
  end

  always @(negedge clk) begin
    expPending = (expQ.size() != 0);
    {expIsFail, expToArx, expData, expVma} = expPending ? expQ[0] : '0;
  end

  function automatic logic [wordW-1:0] randWord();
    return wordW'({$random(seed), $random(seed)});
  endfunction

  function automatic logic [wordW-1:0] fillWord(input logic [memAddrW-1:0] a);
    return wordW'({a, ~a, a ^ 6'h2a, a, ~a, a ^ 6'h15});
  endfunction

  task automatic predict(input memFuncT fn, input logic [magicW-1:0] mg,
                         input logic [vaW-1:0] ad, input logic [wordW-1:0] wd,
                         output logic timed);
    logic [3:0] flags;
    logic       usr;
    logic       pub;
    logic       err;
    expT        e;
    // flags hold loadAr, loadArx, pause, write
    case (fn)
      loadAr:      flags = 4'b1000;
      loadArx:     flags = 4'b0100;
      rwCycle:     flags = 4'b1001;
      rpwCycle:    flags = 4'b1011;
      write:       flags = 4'b0001;
      uncondFetch: flags = 4'b0100;
      adFunc:      flags = {ad[1], ad[2], ad[3], ad[4]};
      default:     flags = 4'b0000;
    endcase
    usr = (fn == adFunc) ? ad[5] : pcUser;
    pub = (fn == adFunc) ? ad[6] : pcPublic;
    err = mg[7] && (ad[vaW-1:23] != '0);
    lastHeld = {4'b0000, flags, usr, pub, mg[5], fn == uncondFetch};
    e.isFail = err;
    e.toArx  = flags[2] && !flags[3];
    e.vma    = {mg[7] ? ad[22:18] : pcSection, ad[17:0]};
    e.data   = refMem[e.vma[memAddrW-1:0]];
    timed = 1'b0;
    if (err || flags[3] || flags[2]) begin
      expQ.push_back(e);
      timed = !stall;
    end
    if (!err && flags[0]) begin
      refMem[e.vma[memAddrW-1:0]] = wd;
    end
  endtask

  task automatic issueOp(input memFuncT fn, input logic [magicW-1:0] mg,
                         input logic [vaW-1:0] ad, input logic [wordW-1:0] wd);
    logic timed;
    int   waited;
    waited = 0;
    @(negedge clk);
    while (!ready && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    if (!ready) begin
      checks.noteFailure("ready stayed low and the strobe was not sent");
      return;
    end
    predict(fn, mg, ad, wd, timed);
    @(posedge clk);
    memStrobe <= 1'b1;
    memFunc   <= fn;
    magic     <= mg;
    adBus     <= ad;
    wrData    <= wd;
    resultDue <= timed;
    idle      <= 1'b0;
    @(posedge clk);
    memStrobe <= 1'b0;
    resultDue <= 1'b0;
  endtask

  task automatic waitDrained();
    int waited;
    waited = 0;
    while (expQ.size() != 0 && waited < 20 * queueDepth) begin
      @(negedge clk);
      waited++;
    end
    if (expQ.size() != 0) begin
      checks.noteFailure("expected results did not all arrive");
      expQ.delete();
    end
  endtask

  task automatic checkHeld();
    @(posedge clk);
    loadHeld <= 1'b1;
    @(posedge clk);
    loadHeld   <= 1'b0;
    condSelVma <= 1'b1;
    heldCheck  <= 1'b1;
    expHeld    <= lastHeld;
    @(posedge clk);
    condSelVma <= 1'b0;
    expHeld    <= {5'b00000, pcUser, pcPublic, pcSection};
    @(posedge clk);
    heldCheck  <= 1'b0;
  endtask

  initial begin
    logic [vaW-1:0]    ad;
    logic [magicW-1:0] mg;
    memFuncT           fn;
    int                issued;
    int                errTotal;
    arstN      = 1'b0;
    memStrobe  = 1'b0;
    memFunc    = nop;
    magic      = '0;
    adBus      = '0;
    wrData     = '0;
    pcUser     = 1'b0;
    pcPublic   = 1'b0;
    pcSection  = '0;
    loadHeld   = 1'b0;
    condSelVma = 1'b0;
    stall      = 1'b0;
    idle       = 1'b1;
    resultDue  = 1'b0;
    heldCheck  = 1'b0;
    repeat (2) @(posedge clk);
    arstN <= 1'b1;
    repeat (3) @(posedge clk);

    // Known contents in every word first
    for (int a = 0; a < 2 ** memAddrW; a++) begin
      issueOp(write, '0, vaW'(a), fillWord(memAddrW'(a)));
    end

    for (int i = 0; i < randOps; i++) begin
      ad = vaW'($random(seed));
      mg = magicW'($random(seed));
      mg[7] = 1'b0;
      case ({$random(seed)} % 4)
        0:       fn = write;
        1:       fn = loadAr;
        2:       fn = loadArx;
        default: fn = uncondFetch;
      endcase
      issueOp(fn, mg, ad, randWord());
    end
    waitDrained();

    // Read-modify-write returns the old word, the next read the new one
    for (int i = 0; i < rmwOps; i++) begin
      ad = vaW'($random(seed));
      mg = magicW'($random(seed));
      mg[7] = 1'b0;
      issueOp((i % 2 != 0) ? rpwCycle : rwCycle, mg, ad, randWord());
      issueOp(loadAr, mg, ad, '0);
    end
    waitDrained();

    // Long address with high bits set must fault and leave memory alone
    for (int i = 0; i < errOps; i++) begin
      ad = vaW'($random(seed));
      ad[23] = 1'b1;
      mg = magicW'($random(seed)) | 9'h080;
      issueOp((i % 2 != 0) ? write : rpwCycle, mg, ad, randWord());
      mg[7] = 1'b0;
      issueOp(loadArx, mg, ad, '0);
    end
    waitDrained();

    @(posedge clk);
    stall <= 1'b1;
    issued = 0;
    do begin
      fn = ({$random(seed)} % 2 != 0) ? loadArx : rwCycle;
      issueOp(fn, '0, vaW'($random(seed)), randWord());
      issued++;
      @(negedge clk);
    end while (ready && issued < 2 * queueDepth);
    if (ready) begin
      checks.noteFailure("ready stayed high with the memory box stalled");
    end
    @(posedge clk);
    stall <= 1'b0;
    waitDrained();

    for (int i = 0; i < heldOps; i++) begin
      @(posedge clk);
      pcUser    <= 1'($random(seed));
      pcPublic  <= 1'($random(seed));
      pcSection <= sectionW'($random(seed));
      fn = memFuncT'(4'({$random(seed)} % 7 + 1));
      issueOp(fn, magicW'($random(seed)), vaW'($random(seed)), randWord());
      waitDrained();
      checkHeld();
    end

    repeat (4) @(posedge clk);
    errTotal = checks.mismatchCount + checks.otherCount;
    $display("Checks done: %0d mismatches, %0d other errors",
             checks.mismatchCount, checks.otherCount);
    if (errTotal == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
